/* hw/pong_pkg.sv */
package pong_pkg;

    typedef logic [11:0] coord_t;   // Pixel coordinate
    typedef logic [2:0]  color_t;   // One bit per channel, R G B
    typedef logic [2:0]  score_t;
    typedef logic [2:0]  speed_t;   // Ball step per clock

    // Visible frame
    localparam coord_t FRAME_WIDTH  = 12'd640;
    localparam coord_t FRAME_HEIGHT = 12'd480;

    // Paddles
    localparam coord_t PADDLE_WIDTH   = 12'd8;
    localparam coord_t PADDLE_HEIGHT  = 12'd60;
    localparam coord_t PADDLE_1_X     = 12'd16;
    localparam coord_t PADDLE_2_X     = 12'd616;
    localparam coord_t PADDLE_START_Y = 12'd210;  // Vertically centred
    localparam coord_t PADDLE_SPEED   = 12'd8;    // Pixels per accepted command

    // Ball
    localparam coord_t BALL_SIZE          = 12'd8;
    localparam coord_t BALL_CENTER_OFFSET = 12'd4;
    localparam coord_t BALL_START_X       = 12'd316;
    localparam coord_t BALL_START_Y       = 12'd236;
    localparam speed_t SERVE_SPEED_X      = 3'd4;
    localparam coord_t COLLISION_OFFSET   = 12'd2;   // Wall bounce band

    // Hit zones along the paddle face, counted from its top edge.
    // Five regular zones plus a corner zone just outside each end.
    localparam int CORNER_ZONE = 4;
    localparam int HIT_ZONE    = 12;

    localparam score_t WIN_SCORE = 3'd7;

    // Command codes in the upper four bits of a key word
    localparam logic [3:0] KEY_UP   = 4'd2;
    localparam logic [3:0] KEY_DOWN = 4'd8;

    // Colours
    localparam color_t PLAYER_1_COLOR = 3'b100;  // Red
    localparam color_t PLAYER_2_COLOR = 3'b001;  // Blue
    localparam color_t BALL_COLOR     = 3'b111;  // White
    localparam color_t BORDER_COLOR   = 3'b010;  // Green
    localparam color_t NO_COLOR       = 3'b000;

endpackage

/* hw/game_control.sv */
`timescale 1ns/1ps

module game_control (
    input  logic BALL_CLOCK,
    input  logic reset,
    input  logic pause_key,
    input  logic clear_key,
    input  logic win_event,
    output logic paused,
    output logic game_clear
);

    logic clear_request;

    // A finished game restarts exactly like a manual clear
    assign clear_request = clear_key | win_event;

    always_ff @(posedge BALL_CLOCK) begin
        if (reset) begin
            paused     <= 1'b1;   // Game comes up paused
            game_clear <= 1'b0;
        end else if (clear_request) begin
            paused     <= 1'b1;
            game_clear <= 1'b1;   // Single cycle, dropped below
        end else begin
            game_clear <= 1'b0;
            if (pause_key) begin
                paused <= ~paused;
            end
        end
    end

endmodule

/* hw/paddle_mover.sv */
`timescale 1ns/1ps

module paddle_mover #(
    parameter pong_pkg::coord_t PADDLE_SPEED = pong_pkg::PADDLE_SPEED
) (
    input  logic             BALL_CLOCK,
    input  logic             reset,
    input  logic             paused,
    input  logic             game_clear,
    input  logic [4:0]       keys,
    output pong_pkg::coord_t paddle_y
);

    logic accept_flag;   // Toggle bit of the last accepted command
    logic new_cmd;
    logic cmd_up;
    logic cmd_down;
    logic at_top;
    logic at_bottom;

    // Key word is a new command only while its toggle differs from ours
    assign new_cmd  = keys[0] != accept_flag;
    assign cmd_up   = new_cmd && (keys[4:1] == pong_pkg::KEY_UP);
    assign cmd_down = new_cmd && (keys[4:1] == pong_pkg::KEY_DOWN);

    // One more step would leave the frame
    assign at_top    = paddle_y <= PADDLE_SPEED;
    assign at_bottom = (pong_pkg::FRAME_HEIGHT - PADDLE_SPEED)
                       <= (paddle_y + pong_pkg::PADDLE_HEIGHT);

    always_ff @(posedge BALL_CLOCK) begin
        if (reset) begin
            paddle_y    <= pong_pkg::PADDLE_START_Y;
            accept_flag <= 1'b0;
        end else if (game_clear) begin
            paddle_y <= pong_pkg::PADDLE_START_Y;   // Toggle tracking carries on
        end else if (!paused) begin
            if (cmd_up) begin
                accept_flag <= ~accept_flag;
                if (at_top) begin
                    paddle_y <= 12'd1;   // First row under the border
                end else begin
                    paddle_y <= paddle_y - PADDLE_SPEED;
                end
            end else if (cmd_down) begin
                accept_flag <= ~accept_flag;
                if (at_bottom) begin
                    paddle_y <= pong_pkg::FRAME_HEIGHT - pong_pkg::PADDLE_HEIGHT - 12'd1;
                end else begin
                    paddle_y <= paddle_y + PADDLE_SPEED;
                end
            end
        end
    end

endmodule

/* hw/ball_engine.sv */
`timescale 1ns/1ps

module ball_engine #(
    parameter pong_pkg::coord_t PADDLE_1_X = pong_pkg::PADDLE_1_X,
    parameter pong_pkg::coord_t PADDLE_2_X = pong_pkg::PADDLE_2_X
) (
    input  logic             BALL_CLOCK,
    input  logic             reset,
    input  logic             paused,
    input  logic             game_clear,
    input  pong_pkg::coord_t paddle_1_y,
    input  pong_pkg::coord_t paddle_2_y,
    output pong_pkg::coord_t ball_x,
    output pong_pkg::coord_t ball_y,
    output pong_pkg::score_t score_1,
    output pong_pkg::score_t score_2,
    output pong_pkg::color_t winner_color,
    output logic             win_event
);

    pong_pkg::speed_t   speed_x;
    pong_pkg::speed_t   speed_y;
    logic               dir_left;       // Heading for paddle 1
    logic               dir_up;
    logic               miss_pending;   // Paddle missed, waiting for the edge

    logic               wall_top;
    logic               wall_bottom;
    logic               step_up;
    pong_pkg::coord_t   next_x;
    pong_pkg::coord_t   next_y;
    logic               band_1;
    logic               band_2;
    logic               in_band;
    pong_pkg::coord_t   face_y;
    logic signed [12:0] hit_ofs;
    logic               zone_hit;
    pong_pkg::speed_t   zone_sx;
    pong_pkg::speed_t   zone_sy;
    logic               zone_keep_dir;
    logic               zone_up;
    logic               at_edge;
    logic               left_half;
    pong_pkg::coord_t   serve_y;

    always_comb begin
        // Wall bands
        wall_top    = ball_y <= pong_pkg::COLLISION_OFFSET;
        wall_bottom = ((pong_pkg::FRAME_HEIGHT - pong_pkg::COLLISION_OFFSET)
                       <= (ball_y + pong_pkg::BALL_SIZE))
                      && ((ball_y + pong_pkg::BALL_SIZE) <= pong_pkg::FRAME_HEIGHT);

        // The bounce takes effect on this very step so y never wraps below 0
        step_up = wall_top ? 1'b0 : (wall_bottom ? 1'b1 : dir_up);

        next_x = dir_left ? ball_x - pong_pkg::coord_t'(speed_x)
                          : ball_x + pong_pkg::coord_t'(speed_x);
        next_y = step_up ? ball_y - pong_pkg::coord_t'(speed_y)
                         : ball_y + pong_pkg::coord_t'(speed_y);

        // Ball edge within one x step of a paddle face
        band_1 = (ball_x >= PADDLE_1_X + pong_pkg::PADDLE_WIDTH)
                 && (ball_x <= PADDLE_1_X + pong_pkg::PADDLE_WIDTH
                               + pong_pkg::coord_t'(speed_x));
        band_2 = ((ball_x + pong_pkg::BALL_SIZE) >= PADDLE_2_X - pong_pkg::coord_t'(speed_x))
                 && ((ball_x + pong_pkg::BALL_SIZE) <= PADDLE_2_X);
        in_band = dir_left ? band_1 : band_2;   // Only the paddle ahead counts

        // Ball centre relative to the top of the approached paddle
        face_y  = dir_left ? paddle_1_y : paddle_2_y;
        hit_ofs = $signed({1'b0, ball_y + pong_pkg::BALL_CENTER_OFFSET})
                  - $signed({1'b0, face_y});

        zone_hit      = 1'b1;
        zone_keep_dir = 1'b0;
        zone_up       = 1'b0;
        zone_sx       = 3'd0;
        zone_sy       = 3'd0;
        if (hit_ofs < -pong_pkg::CORNER_ZONE) begin
            zone_hit = 1'b0;
        end else if (hit_ofs < 0) begin                    // Upper corner
            zone_sx = 3'd1;
            zone_sy = 3'd3;
            zone_up = 1'b1;
        end else if (hit_ofs < pong_pkg::HIT_ZONE) begin
            zone_sx = 3'd2;
            zone_sy = 3'd2;
            zone_up = 1'b1;
        end else if (hit_ofs < 2 * pong_pkg::HIT_ZONE) begin
            zone_sx = 3'd3;
            zone_sy = 3'd1;
            zone_up = 1'b1;
        end else if (hit_ofs < 3 * pong_pkg::HIT_ZONE) begin
            zone_sx       = 3'd4;   // Straight return
            zone_keep_dir = 1'b1;
        end else if (hit_ofs < 4 * pong_pkg::HIT_ZONE) begin
            zone_sx = 3'd3;
            zone_sy = 3'd1;
        end else if (hit_ofs < 5 * pong_pkg::HIT_ZONE) begin
            zone_sx = 3'd2;
            zone_sy = 3'd2;
        end else if (hit_ofs < 5 * pong_pkg::HIT_ZONE + pong_pkg::CORNER_ZONE) begin
            zone_sx = 3'd1;
            zone_sy = 3'd3;
        end else begin
            zone_hit = 1'b0;
        end

        // Re-serve point after a miss
        at_edge = ((ball_x >= 12'd1) && (ball_x <= 12'd5))
                  || ((ball_x >= pong_pkg::FRAME_WIDTH - pong_pkg::BALL_SIZE)
                      && (ball_x <= pong_pkg::FRAME_WIDTH - 12'd1));
        left_half = ball_x < (pong_pkg::FRAME_WIDTH >> 1);
        serve_y   = (left_half ? paddle_1_y : paddle_2_y)
                    + (pong_pkg::PADDLE_HEIGHT >> 1) - pong_pkg::BALL_CENTER_OFFSET;
    end

    always_ff @(posedge BALL_CLOCK) begin
        if (reset) begin
            ball_x       <= pong_pkg::BALL_START_X;
            ball_y       <= pong_pkg::BALL_START_Y;
            speed_x      <= pong_pkg::SERVE_SPEED_X;
            speed_y      <= 3'd0;
            dir_left     <= 1'b0;
            dir_up       <= 1'b0;
            miss_pending <= 1'b0;
            score_1      <= 3'd0;
            score_2      <= 3'd0;
            winner_color <= pong_pkg::NO_COLOR;
            win_event    <= 1'b0;
        end else if (game_clear) begin
            // winner_color stays up on the centre box while paused
            ball_x       <= pong_pkg::BALL_START_X;
            ball_y       <= pong_pkg::BALL_START_Y;
            speed_x      <= pong_pkg::SERVE_SPEED_X;
            speed_y      <= 3'd0;
            dir_left     <= 1'b0;
            dir_up       <= 1'b0;
            miss_pending <= 1'b0;
            score_1      <= 3'd0;
            score_2      <= 3'd0;
            win_event    <= 1'b0;
        end else begin
            win_event <= 1'b0;
            if (!paused) begin
                if (!miss_pending && !win_event) begin
                    winner_color <= pong_pkg::NO_COLOR;
                end
                ball_x <= next_x;
                ball_y <= next_y;
                dir_up <= step_up;

                if (miss_pending) begin
                    if (at_edge) begin
                        ball_x       <= pong_pkg::BALL_START_X;
                        ball_y       <= serve_y;   // Centred on that side's paddle
                        speed_x      <= pong_pkg::SERVE_SPEED_X;
                        speed_y      <= 3'd0;
                        dir_left     <= 1'b0;
                        miss_pending <= 1'b0;
                        win_event    <= winner_color != pong_pkg::NO_COLOR;
                    end
                end else if (in_band) begin
                    if (zone_hit) begin
                        dir_left <= ~dir_left;   // Away from the paddle
                        speed_x  <= zone_sx;
                        speed_y  <= zone_sy;
                        if (!zone_keep_dir) begin
                            dir_up <= zone_up;
                        end
                    end else begin
                        miss_pending <= 1'b1;
                        if (dir_left) begin   // Paddle 1 missed
                            if (score_2 == pong_pkg::WIN_SCORE) begin
                                score_1      <= 3'd0;
                                score_2      <= 3'd0;
                                winner_color <= pong_pkg::PLAYER_2_COLOR;
                            end else begin
                                score_2 <= score_2 + 3'd1;
                            end
                        end else begin        // Paddle 2 missed
                            if (score_1 == pong_pkg::WIN_SCORE) begin
                                score_1      <= 3'd0;
                                score_2      <= 3'd0;
                                winner_color <= pong_pkg::PLAYER_1_COLOR;
                            end else begin
                                score_1 <= score_1 + 3'd1;
                            end
                        end
                    end
                end
            end
        end
    end

endmodule

/* hw/pixel_mixer.sv */
`timescale 1ns/1ps

module pixel_mixer #(
    parameter pong_pkg::coord_t PADDLE_1_X = pong_pkg::PADDLE_1_X,
    parameter pong_pkg::coord_t PADDLE_2_X = pong_pkg::PADDLE_2_X
) (
    input  pong_pkg::coord_t x,
    input  pong_pkg::coord_t y,
    input  pong_pkg::coord_t ball_x,
    input  pong_pkg::coord_t ball_y,
    input  pong_pkg::coord_t paddle_1_y,
    input  pong_pkg::coord_t paddle_2_y,
    input  pong_pkg::color_t winner_color,
    output pong_pkg::color_t color
);

    localparam pong_pkg::coord_t CENTER_X =
        (pong_pkg::FRAME_WIDTH >> 1) - pong_pkg::BALL_CENTER_OFFSET;
    localparam pong_pkg::coord_t CENTER_Y =
        (pong_pkg::FRAME_HEIGHT >> 1) - pong_pkg::BALL_CENTER_OFFSET;

    logic in_ball;
    logic in_center;
    logic in_paddle_1;
    logic in_paddle_2;
    logic on_border;

    // Boxes include both edges, position to position plus size
    assign in_ball = (x >= ball_x) && (x <= ball_x + pong_pkg::BALL_SIZE)
                     && (y >= ball_y) && (y <= ball_y + pong_pkg::BALL_SIZE);
    assign in_center = (x >= CENTER_X) && (x <= CENTER_X + pong_pkg::BALL_SIZE)
                       && (y >= CENTER_Y) && (y <= CENTER_Y + pong_pkg::BALL_SIZE);
    assign in_paddle_1 = (x >= PADDLE_1_X) && (x <= PADDLE_1_X + pong_pkg::PADDLE_WIDTH)
                         && (y >= paddle_1_y) && (y <= paddle_1_y + pong_pkg::PADDLE_HEIGHT);
    assign in_paddle_2 = (x >= PADDLE_2_X) && (x <= PADDLE_2_X + pong_pkg::PADDLE_WIDTH)
                         && (y >= paddle_2_y) && (y <= paddle_2_y + pong_pkg::PADDLE_HEIGHT);
    assign on_border = (x == 12'd1) || (x == pong_pkg::FRAME_WIDTH)
                       || (y == 12'd1) || (y == pong_pkg::FRAME_HEIGHT);

    always_comb begin
        if (in_ball) begin
            color = pong_pkg::BALL_COLOR;
        end else if ((winner_color != pong_pkg::NO_COLOR) && in_center) begin
            color = winner_color;   // Win marker in the middle
        end else if (in_paddle_1) begin
            color = pong_pkg::PLAYER_1_COLOR;
        end else if (in_paddle_2) begin
            color = pong_pkg::PLAYER_2_COLOR;
        end else if (on_border) begin
            color = pong_pkg::BORDER_COLOR;
        end else begin
            color = pong_pkg::NO_COLOR;
        end
    end

endmodule

/* hw/pong_top.sv */
`timescale 1ns/1ps

module pong_top #(
    parameter pong_pkg::coord_t PADDLE_1_X   = pong_pkg::PADDLE_1_X,
    parameter pong_pkg::coord_t PADDLE_2_X   = pong_pkg::PADDLE_2_X,
    parameter pong_pkg::coord_t PADDLE_SPEED = pong_pkg::PADDLE_SPEED
) (
    input  logic             BALL_CLOCK,
    input  logic             reset,
    input  pong_pkg::coord_t x,
    input  pong_pkg::coord_t y,
    input  logic [4:0]       keys_1,
    input  logic [4:0]       keys_2,
    input  logic             pause_key,
    input  logic             clear_key,
    output pong_pkg::color_t color,
    output pong_pkg::score_t score_1,
    output pong_pkg::score_t score_2
);

    logic             paused;
    logic             game_clear;
    logic             win_event;
    pong_pkg::coord_t paddle_1_y;
    pong_pkg::coord_t paddle_2_y;
    pong_pkg::coord_t ball_x;
    pong_pkg::coord_t ball_y;
    pong_pkg::color_t winner_color;

    game_control u_game_control (
        .BALL_CLOCK (BALL_CLOCK),
        .reset      (reset),
        .pause_key  (pause_key),
        .clear_key  (clear_key),
        .win_event  (win_event),
        .paused     (paused),
        .game_clear (game_clear)
    );

    paddle_mover #(
        .PADDLE_SPEED (PADDLE_SPEED)
    ) u_paddle_1 (
        .BALL_CLOCK (BALL_CLOCK),
        .reset      (reset),
        .paused     (paused),
        .game_clear (game_clear),
        .keys       (keys_1),
        .paddle_y   (paddle_1_y)
    );

    paddle_mover #(
        .PADDLE_SPEED (PADDLE_SPEED)
    ) u_paddle_2 (
        .BALL_CLOCK (BALL_CLOCK),
        .reset      (reset),
        .paused     (paused),
        .game_clear (game_clear),
        .keys       (keys_2),
        .paddle_y   (paddle_2_y)
    );

    ball_engine #(
        .PADDLE_1_X (PADDLE_1_X),
        .PADDLE_2_X (PADDLE_2_X)
    ) u_ball_engine (
        .BALL_CLOCK   (BALL_CLOCK),
        .reset        (reset),
        .paused       (paused),
        .game_clear   (game_clear),
        .paddle_1_y   (paddle_1_y),
        .paddle_2_y   (paddle_2_y),
        .ball_x       (ball_x),
        .ball_y       (ball_y),
        .score_1      (score_1),
        .score_2      (score_2),
        .winner_color (winner_color),
        .win_event    (win_event)
    );

    pixel_mixer #(
        .PADDLE_1_X (PADDLE_1_X),
        .PADDLE_2_X (PADDLE_2_X)
    ) u_pixel_mixer (
        .x            (x),
        .y            (y),
        .ball_x       (ball_x),
        .ball_y       (ball_y),
        .paddle_1_y   (paddle_1_y),
        .paddle_2_y   (paddle_2_y),
        .winner_color (winner_color),
        .color        (color)
    );

endmodule

/* test/pong_checks.svh */
// Reference pixel colour from the model positions
function automatic pong_pkg::color_t expected_color(input pong_pkg::coord_t px,
                                                    input pong_pkg::coord_t py);
    pong_pkg::coord_t cx;
    pong_pkg::coord_t cy;
    cx = pong_pkg::FRAME_WIDTH / 2 - pong_pkg::BALL_CENTER_OFFSET;
    cy = pong_pkg::FRAME_HEIGHT / 2 - pong_pkg::BALL_CENTER_OFFSET;
    if (px >= m_bx && px <= m_bx + pong_pkg::BALL_SIZE
        && py >= m_by && py <= m_by + pong_pkg::BALL_SIZE) begin
        return pong_pkg::BALL_COLOR;
    end else if (m_win != pong_pkg::NO_COLOR && px >= cx && px <= cx + pong_pkg::BALL_SIZE
                 && py >= cy && py <= cy + pong_pkg::BALL_SIZE) begin
        return m_win;   // Win marker
    end else if (px >= pong_pkg::PADDLE_1_X && px <= pong_pkg::PADDLE_1_X + pong_pkg::PADDLE_WIDTH
                 && py >= m_p1 && py <= m_p1 + pong_pkg::PADDLE_HEIGHT) begin
        return pong_pkg::PLAYER_1_COLOR;
    end else if (px >= pong_pkg::PADDLE_2_X && px <= pong_pkg::PADDLE_2_X + pong_pkg::PADDLE_WIDTH
                 && py >= m_p2 && py <= m_p2 + pong_pkg::PADDLE_HEIGHT) begin
        return pong_pkg::PLAYER_2_COLOR;
    end else if (px == 1 || px == pong_pkg::FRAME_WIDTH || py == 1
                 || py == pong_pkg::FRAME_HEIGHT) begin
        return pong_pkg::BORDER_COLOR;
    end
    return pong_pkg::NO_COLOR;
endfunction

task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
        $display("FAIL at %0t: %s is %0d, expected %0d", $time, name, got, exp);
        $display("=== FAIL ===");
        $fatal(1, "mismatch on %s", name);
    end
endtask

task automatic probe(input pong_pkg::coord_t px, input pong_pkg::coord_t py);
    x = px;
    y = py;
    #1;
    check($sformatf("color at (%0d,%0d)", px, py), 32'(color), 32'(expected_color(px, py)));
endtask

// Eight probes, all inside the high phase of the clock
task automatic probe_frame();
    probe(m_bx, m_by);   // Ball corners
    probe(m_bx + pong_pkg::BALL_SIZE, m_by + pong_pkg::BALL_SIZE);
    probe(m_bx + pong_pkg::BALL_SIZE + 1, m_by + 4);
    probe(316, 236);     // Centre box
    probe(20, m_p1);
    probe(20, m_p1 + pong_pkg::PADDLE_HEIGHT + 1);   // Just below paddle 1
    probe(620, m_p2 - 1);
    probe(620, m_p2 + pong_pkg::PADDLE_HEIGHT);
endtask

/* test/pong_tb.sv */
`timescale 1ns/1ps

module pong_tb;

    localparam int MAX_CYCLES = 4000;   // Whole sequence takes about 1700 cycles

    logic             BALL_CLOCK;
    logic             reset;
    pong_pkg::coord_t x;
    pong_pkg::coord_t y;
    logic [4:0]       keys_1;
    logic [4:0]       keys_2;
    logic             pause_key;
    logic             clear_key;
    pong_pkg::color_t color;
    pong_pkg::score_t score_1;
    pong_pkg::score_t score_2;

    // Expected game state, one step per clock
    pong_pkg::coord_t m_p1;
    pong_pkg::coord_t m_p2;
    pong_pkg::coord_t m_bx;
    pong_pkg::coord_t m_by;
    pong_pkg::score_t m_s1;
    pong_pkg::score_t m_s2;
    pong_pkg::color_t m_win;
    logic             m_f1;
    logic             m_f2;
    logic             m_left;
    logic             m_miss;
    logic             m_paused;
    logic             m_clr;
    logic             m_ev;
    logic [4:0]       k1;
    logic [4:0]       k2;
    integer           seed;
    integer           r;

    `include "pong_checks.svh"

    pong_top uut (
        .BALL_CLOCK (BALL_CLOCK),
        .reset      (reset),
        .x          (x),
        .y          (y),
        .keys_1     (keys_1),
        .keys_2     (keys_2),
        .pause_key  (pause_key),
        .clear_key  (clear_key),
        .color      (color),
        .score_1    (score_1),
        .score_2    (score_2)
    );

    initial begin
        BALL_CLOCK = 1'b0;
        forever #10 BALL_CLOCK = ~BALL_CLOCK;
    end

    initial begin
        repeat (MAX_CYCLES) @(posedge BALL_CLOCK);
        $display("Timeout: the sequence did not finish within %0d cycles", MAX_CYCLES);
        $display("=== FAIL ===");
        $fatal(1, "watchdog expired");
    end

    task automatic move_paddle(inout pong_pkg::coord_t p, inout logic f, input logic [4:0] k);
        if (k[0] != f && (k[4:1] == pong_pkg::KEY_UP || k[4:1] == pong_pkg::KEY_DOWN)) begin
            f = ~f;
            if (k[4:1] == pong_pkg::KEY_UP) begin
                p = (p > pong_pkg::PADDLE_SPEED) ? p - pong_pkg::PADDLE_SPEED : 12'd1;
            end else if (p + pong_pkg::PADDLE_HEIGHT
                         >= pong_pkg::FRAME_HEIGHT - pong_pkg::PADDLE_SPEED) begin
                p = pong_pkg::FRAME_HEIGHT - pong_pkg::PADDLE_HEIGHT - 12'd1;
            end else begin
                p = p + pong_pkg::PADDLE_SPEED;
            end
        end
    endtask

    // Only straight returns and misses occur in this sequence
    task automatic model_step(input logic pk, input logic ck);
        logic             band;
        logic             n_ev;
        int               ofs;
        pong_pkg::coord_t nx;
        n_ev = 1'b0;
        if (m_clr) begin
            m_p1   = pong_pkg::PADDLE_START_Y;
            m_p2   = pong_pkg::PADDLE_START_Y;
            m_bx   = pong_pkg::BALL_START_X;
            m_by   = pong_pkg::BALL_START_Y;
            m_left = 1'b0;
            m_miss = 1'b0;
            m_s1   = 3'd0;
            m_s2   = 3'd0;
        end else if (!m_paused) begin
            if (!m_miss && !m_ev) begin
                m_win = pong_pkg::NO_COLOR;
            end
            nx = m_left ? m_bx - 12'(pong_pkg::SERVE_SPEED_X) : m_bx + 12'(pong_pkg::SERVE_SPEED_X);
            band = m_left ? (m_bx >= 24 && m_bx <= 28) : (m_bx + 8 >= 612 && m_bx + 8 <= 616);
            ofs = int'(m_by) + int'(pong_pkg::BALL_CENTER_OFFSET) - int'(m_left ? m_p1 : m_p2);
            if (m_miss) begin
                if ((m_bx >= 1 && m_bx <= 5) || (m_bx >= pong_pkg::FRAME_WIDTH - 8
                                                 && m_bx < pong_pkg::FRAME_WIDTH)) begin
                    nx     = pong_pkg::BALL_START_X;   // Serve again
                    m_by   = (m_bx < pong_pkg::FRAME_WIDTH / 2 ? m_p1 : m_p2) + 12'd26;
                    m_left = 1'b0;
                    m_miss = 1'b0;
                    n_ev   = m_win != pong_pkg::NO_COLOR;
                end
            end else if (band) begin
                if (ofs >= 2 * pong_pkg::HIT_ZONE && ofs < 3 * pong_pkg::HIT_ZONE) begin
                    m_left = ~m_left;
                end else if (ofs < -pong_pkg::CORNER_ZONE
                             || ofs >= 5 * pong_pkg::HIT_ZONE + pong_pkg::CORNER_ZONE) begin
                    m_miss = 1'b1;
                    if ((m_left ? m_s2 : m_s1) == pong_pkg::WIN_SCORE) begin
                        m_s1  = 3'd0;
                        m_s2  = 3'd0;
                        m_win = m_left ? pong_pkg::PLAYER_2_COLOR : pong_pkg::PLAYER_1_COLOR;
                    end else if (m_left) begin
                        m_s2 = m_s2 + 3'd1;
                    end else begin
                        m_s1 = m_s1 + 3'd1;
                    end
                end
            end
            m_bx = nx;
            move_paddle(m_p1, m_f1, k1);
            move_paddle(m_p2, m_f2, k2);
        end
        m_paused = (ck || m_ev) ? 1'b1 : m_paused ^ pk;
        m_clr    = ck || m_ev;
        m_ev     = n_ev;
    endtask

    task automatic run_cycle(input logic pk, input logic ck);
        @(negedge BALL_CLOCK);
        keys_1    = k1;
        keys_2    = k2;
        pause_key = pk;
        clear_key = ck;
        model_step(pk, ck);
        @(posedge BALL_CLOCK);
        probe_frame();
        check("score_1", 32'(score_1), 32'(m_s1));
        check("score_2", 32'(score_2), 32'(m_s2));
    endtask

    initial begin
        seed      = 15;
        reset     = 1'b1;
        x         = '0;
        y         = '0;
        k1        = 5'd0;
        k2        = 5'd0;
        keys_1    = 5'd0;
        keys_2    = 5'd0;
        pause_key = 1'b0;
        clear_key = 1'b0;
        m_p1      = pong_pkg::PADDLE_START_Y;
        m_p2      = pong_pkg::PADDLE_START_Y;
        m_bx      = pong_pkg::BALL_START_X;
        m_by      = pong_pkg::BALL_START_Y;
        m_s1      = 3'd0;
        m_s2      = 3'd0;
        m_win     = pong_pkg::NO_COLOR;
        {m_f1, m_f2, m_left, m_miss, m_clr, m_ev} = 6'b0;
        m_paused  = 1'b1;
        repeat (8) @(negedge BALL_CLOCK);
        reset = 1'b0;

        repeat (20) run_cycle(1'b0, 1'b0);   // Comes up paused
        probe(1, 100);
        probe(640, 300);
        probe(300, 1);
        probe(300, 480);

        // Random words, some with a stale toggle
        run_cycle(1'b1, 1'b0);
        for (int i = 0; i < 16; i++) begin
            r  = $random(seed);
            k1 = {r[1] ? pong_pkg::KEY_UP : (r[0] ? pong_pkg::KEY_DOWN : 4'd5), r[2]};
            k2 = {r[4] ? pong_pkg::KEY_UP : (r[3] ? pong_pkg::KEY_DOWN : 4'd5), r[5]};
            run_cycle(1'b0, 1'b0);
        end
        repeat (45) begin   // Into the top and bottom clamps
            k1 = {pong_pkg::KEY_UP, ~m_f1};
            k2 = {pong_pkg::KEY_DOWN, ~m_f2};
            run_cycle(1'b0, 1'b0);
        end
        run_cycle(1'b0, 1'b1);

        // Straight rally, paddle 2 then paddle 1
        run_cycle(1'b1, 1'b0);
        while (!m_left) begin
            run_cycle(1'b0, 1'b0);
        end
        while (m_left) begin
            run_cycle(1'b0, 1'b0);
        end
        while (!m_left) begin
            run_cycle(1'b0, 1'b0);
        end

        // Paddle 2 jumps 40 px off the serve line each round
        for (int round = 0; round < 8; round++) begin
            repeat (5) begin
                k2 = {(round % 2 == 0) ? pong_pkg::KEY_UP : pong_pkg::KEY_DOWN, ~m_f2};
                run_cycle(1'b0, 1'b0);
            end
            while (!m_miss) begin
                run_cycle(1'b0, 1'b0);
            end
            while (m_miss) begin
                run_cycle(1'b0, 1'b0);
            end
        end
        repeat (25) run_cycle(1'b0, 1'b0);   // Win restart, then frozen

        // Clear in the middle of play, with a point already scored
        run_cycle(1'b1, 1'b0);
        for (int i = 0; i < 20; i++) begin
            if (i < 3) begin
                k1 = {pong_pkg::KEY_DOWN, ~m_f1};
            end
            if (i < 5) begin
                k2 = {pong_pkg::KEY_UP, ~m_f2};
            end
            run_cycle(1'b0, 1'b0);
        end
        while (!m_miss) begin
            run_cycle(1'b0, 1'b0);
        end
        run_cycle(1'b0, 1'b1);
        repeat (20) run_cycle(1'b0, 1'b0);

        $display("=== PASS ===");
        $finish;
    end

endmodule

/* src.f */
hw/pong_pkg.sv
hw/game_control.sv
hw/paddle_mover.sv
hw/ball_engine.sv
hw/pixel_mixer.sv
hw/pong_top.sv
test/pong_tb.sv
+incdir+test

/* run.sh */
#!/bin/bash
# Build and run the Pong testbench with Verilator, result taken from sim.log
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --top-module pong_tb -f src.f -o pong_sim \
    && ./obj_dir/pong_sim > sim.log 2>&1 \
    || echo "Simulation returned an error status"

cat sim.log 2>/dev/null

if [ ! -f sim.log ] || grep -q "=== FAIL ===" sim.log; then
    exit 1
fi
grep -q "=== PASS ===" sim.log || exit 1
exit 0
